// ==== source/exec_pkg.sv ====
package exec_pkg;

    // issue slots per cycle
    localparam int issue_width = 2;

    localparam int word_width     = 32;
    localparam int addr_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int cnt_width      = 64;
    localparam int shamt_width    = 5;

    // byte distance to the next instruction
    localparam int pc_step = 4;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [addr_width-1:0]     addr_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [cnt_width-1:0]      cnt_t;

    typedef enum logic [4:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_lui,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_jal,
        op_jalr,
        op_load,
        op_store,
        op_rdcnt_lo,
        op_rdcnt_hi
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        alu_op_e   op;
        word_t     src_a;
        word_t     src_b;
        word_t     imm;
        reg_addr_t rd_addr;
        logic      rd_we;
    } dispatch_ex_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        reg_addr_t rd_addr;
        logic      rd_we;
        word_t     rd_data;
        logic      mem_req;
        logic      mem_we;
        addr_t     mem_addr;
        word_t     mem_wdata;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_fwd_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // ops that only the main pipe can execute
    function automatic logic is_mem_or_cnt(alu_op_e op);
        return op inside {op_load, op_store, op_rdcnt_lo, op_rdcnt_hi};
    endfunction

endpackage

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::alu_op_e op_i,
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    output exec_pkg::word_t   result_o
);

    logic [exec_pkg::shamt_width-1:0] shamt;
    logic                             lt_signed;
    logic                             lt_unsigned;

    assign shamt       = b_i[exec_pkg::shamt_width-1:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            exec_pkg::op_add: begin
                result_o = a_i + b_i;
            end
            exec_pkg::op_sub: begin
                result_o = a_i - b_i;
            end
            exec_pkg::op_and: begin
                result_o = a_i & b_i;
            end
            exec_pkg::op_or: begin
                result_o = a_i | b_i;
            end
            exec_pkg::op_xor: begin
                result_o = a_i ^ b_i;
            end
            exec_pkg::op_sll: begin
                result_o = a_i << shamt;
            end
            exec_pkg::op_srl: begin
                result_o = a_i >> shamt;
            end
            exec_pkg::op_sra: begin
                result_o = exec_pkg::word_t'($signed(a_i) >>> shamt);
            end
            exec_pkg::op_slt: begin
                result_o = {{(exec_pkg::word_width-1){1'b0}}, lt_signed};
            end
            exec_pkg::op_sltu: begin
                result_o = {{(exec_pkg::word_width-1){1'b0}}, lt_unsigned};
            end
            // operand b carries the immediate here
            exec_pkg::op_lui: begin
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
    input  logic                valid_i,
    input  exec_pkg::alu_op_e   op_i,
    input  exec_pkg::addr_t     pc_i,
    input  exec_pkg::word_t     a_i,
    input  exec_pkg::word_t     b_i,
    input  exec_pkg::word_t     imm_i,
    output exec_pkg::redirect_t redirect_o,
    output exec_pkg::word_t     link_o
);

    logic            cond;
    exec_pkg::addr_t target;

    always_comb begin
        case (op_i)
            exec_pkg::op_beq:  cond = a_i == b_i;
            exec_pkg::op_bne:  cond = a_i != b_i;
            exec_pkg::op_blt:  cond = $signed(a_i) < $signed(b_i);
            exec_pkg::op_bge:  cond = $signed(a_i) >= $signed(b_i);
            exec_pkg::op_jal:  cond = 1'b1;
            exec_pkg::op_jalr: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

    // jalr is register relative, everything else pc relative
    always_comb begin
        if (op_i == exec_pkg::op_jalr) begin
            target = (a_i + imm_i) & ~exec_pkg::addr_t'(1);
        end else begin
            target = pc_i + imm_i;
        end
    end

    assign redirect_o.taken  = valid_i & cond;
    assign redirect_o.target = redirect_o.taken ? target : '0;
    assign link_o            = pc_i + exec_pkg::word_t'(exec_pkg::pc_step);

    // targets must stay halfword aligned at least
    always_comb begin
        if (redirect_o.taken) begin
            assert (redirect_o.target[0] == 1'b0)
                else $error("branch_resolve: odd redirect target %h", redirect_o.target);
        end
    end

endmodule

// ==== source/main_pipe.sv ====
`timescale 1ns/1ps

module main_pipe (
    input  logic                   clk,
    input  exec_pkg::dispatch_ex_t ex_i,
    input  exec_pkg::cnt_t         cnt_i,
    output exec_pkg::ex_mem_t      result_o,
    output exec_pkg::redirect_t    redirect_o
);

    exec_pkg::word_t alu_b;
    exec_pkg::word_t alu_result;
    exec_pkg::word_t link;
    logic            is_load;
    logic            is_store;

    assign alu_b = (ex_i.op == exec_pkg::op_lui) ? ex_i.imm : ex_i.src_b;

    exec_alu u_alu (
        .op_i     (ex_i.op),
        .a_i      (ex_i.src_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_resolve u_branch (
        .valid_i    (ex_i.valid),
        .op_i       (ex_i.op),
        .pc_i       (ex_i.pc),
        .a_i        (ex_i.src_a),
        .b_i        (ex_i.src_b),
        .imm_i      (ex_i.imm),
        .redirect_o (redirect_o),
        .link_o     (link)
    );

    assign is_load  = ex_i.op == exec_pkg::op_load;
    assign is_store = ex_i.op == exec_pkg::op_store;

    always_comb begin
        result_o         = '0;
        result_o.valid   = ex_i.valid;
        result_o.pc      = ex_i.pc;
        result_o.rd_addr = ex_i.rd_addr;
        result_o.rd_we   = ex_i.valid & ex_i.rd_we;

        case (ex_i.op)
            exec_pkg::op_jal, exec_pkg::op_jalr: begin
                result_o.rd_data = link;
            end
            exec_pkg::op_rdcnt_lo: begin
                result_o.rd_data = cnt_i[exec_pkg::word_width-1:0];
            end
            exec_pkg::op_rdcnt_hi: begin
                result_o.rd_data = cnt_i[exec_pkg::cnt_width-1:exec_pkg::word_width];
            end
            default: begin
                result_o.rd_data = alu_result;
            end
        endcase

        // load/store request
        result_o.mem_req = ex_i.valid & (is_load | is_store);
        result_o.mem_we  = ex_i.valid & is_store;
        if (result_o.mem_req) begin
            result_o.mem_addr  = ex_i.src_a + ex_i.imm;
            result_o.mem_wdata = ex_i.src_b;
        end
    end

    // a memory op never resolves as a branch
    assert property (@(posedge clk)
        result_o.mem_req |-> !redirect_o.taken)
        else $error("main_pipe: memory request together with a redirect");

endmodule

// ==== source/deputy_pipe.sv ====
`timescale 1ns/1ps

module deputy_pipe (
    input  exec_pkg::dispatch_ex_t ex_i,
    output exec_pkg::ex_mem_t      result_o,
    output exec_pkg::redirect_t    redirect_o
);

    exec_pkg::word_t alu_b;
    exec_pkg::word_t alu_result;
    exec_pkg::word_t link;
    logic            is_jump;

    assign alu_b = (ex_i.op == exec_pkg::op_lui) ? ex_i.imm : ex_i.src_b;

    exec_alu u_alu (
        .op_i     (ex_i.op),
        .a_i      (ex_i.src_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_resolve u_branch (
        .valid_i    (ex_i.valid),
        .op_i       (ex_i.op),
        .pc_i       (ex_i.pc),
        .a_i        (ex_i.src_a),
        .b_i        (ex_i.src_b),
        .imm_i      (ex_i.imm),
        .redirect_o (redirect_o),
        .link_o     (link)
    );

    assign is_jump = ex_i.op inside {exec_pkg::op_jal, exec_pkg::op_jalr};

    // no memory path on this pipe
    always_comb begin
        result_o         = '0;
        result_o.valid   = ex_i.valid;
        result_o.pc      = ex_i.pc;
        result_o.rd_addr = ex_i.rd_addr;
        result_o.rd_we   = ex_i.valid & ex_i.rd_we;
        result_o.rd_data = is_jump ? link : alu_result;
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                                              clk,
    input  logic                                              arst_n_i,
    input  logic                                              flush_i,
    input  logic                                              pause_i,
    input  exec_pkg::dispatch_ex_t [exec_pkg::issue_width-1:0] ex_i,
    output exec_pkg::ex_mem_t      [exec_pkg::issue_width-1:0] mem_o,
    output exec_pkg::reg_fwd_t     [exec_pkg::issue_width-1:0] fwd_o,
    output logic                                              branch_flush_o,
    output exec_pkg::addr_t                                   branch_target_o
);

    exec_pkg::dispatch_ex_t [exec_pkg::issue_width-1:0] slot;
    exec_pkg::dispatch_ex_t                             main_ex;
    exec_pkg::dispatch_ex_t                             deputy_ex;
    logic                                               swap;

    exec_pkg::ex_mem_t   [exec_pkg::issue_width-1:0] pipe_res;
    exec_pkg::redirect_t [exec_pkg::issue_width-1:0] redir;

    logic                main_older;
    exec_pkg::redirect_t older_redir;
    exec_pkg::redirect_t younger_redir;

    exec_pkg::ex_mem_t [exec_pkg::issue_width-1:0] mem_d;
    exec_pkg::ex_mem_t [exec_pkg::issue_width-1:0] mem_q;

    exec_pkg::cnt_t cnt_q;

    // an invalid slot behaves as a nop
    for (genvar i = 0; i < exec_pkg::issue_width; i++) begin : g_slot
        assign slot[i] = ex_i[i].valid ? ex_i[i] : '0;
    end

    // memory and counter ops must land on the main pipe
    assign swap      = exec_pkg::is_mem_or_cnt(slot[1].op);
    assign main_ex   = swap ? slot[1] : slot[0];
    assign deputy_ex = swap ? slot[0] : slot[1];

    // free running, paused cycles included
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + exec_pkg::cnt_t'(1);
        end
    end

    main_pipe u_main_pipe (
        .clk        (clk),
        .ex_i       (main_ex),
        .cnt_i      (cnt_q),
        .result_o   (pipe_res[0]),
        .redirect_o (redir[0])
    );

    deputy_pipe u_deputy_pipe (
        .ex_i       (deputy_ex),
        .result_o   (pipe_res[1]),
        .redirect_o (redir[1])
    );

    // forwarding sees results before any squash
    for (genvar i = 0; i < exec_pkg::issue_width; i++) begin : g_fwd
        assign fwd_o[i].we   = pipe_res[i].rd_we;
        assign fwd_o[i].addr = pipe_res[i].rd_addr;
        assign fwd_o[i].data = pipe_res[i].rd_data;
    end

    // program order by pc
    assign main_older    = main_ex.pc < deputy_ex.pc;
    assign older_redir   = main_older ? redir[0] : redir[1];
    assign younger_redir = main_older ? redir[1] : redir[0];

    assign branch_flush_o = older_redir.taken | younger_redir.taken;

    always_comb begin
        if (older_redir.taken) begin
            branch_target_o = older_redir.target;
        end else if (younger_redir.taken) begin
            branch_target_o = younger_redir.target;
        end else begin
            branch_target_o = '0;
        end
    end

    // taken older branch kills the younger one
    always_comb begin
        mem_d = pipe_res;
        if (older_redir.taken) begin
            if (main_older) begin
                mem_d[1] = '0;
            end else begin
                mem_d[0] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q <= '0;
        end else if (flush_i) begin
            mem_q <= '0;
        end else if (!pause_i) begin
            mem_q <= mem_d;
        end
    end

    assign mem_o = mem_q;

    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ex_i[0].valid && ex_i[1].valid
          && exec_pkg::is_mem_or_cnt(ex_i[0].op)
          && exec_pkg::is_mem_or_cnt(ex_i[1].op)))
        else $error("execute_stage: two memory or counter ops in one pair");

    assert property (@(posedge clk) disable iff (!arst_n_i) !mem_o[1].mem_req)
        else $error("execute_stage: memory request on the deputy pipe");

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n_o
);

    localparam int reset_cycles = 5;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release a little after an edge, away from the sampling point
    initial begin
        arst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #3;
        arst_n_o = 1'b1;
    end

endmodule

// ==== verif/tb_execute_stage.sv ====
`timescale 1ns/1ps

module tb_execute_stage;

    typedef exec_pkg::dispatch_ex_t [exec_pkg::issue_width-1:0] ex_pair_t;
    typedef exec_pkg::ex_mem_t [exec_pkg::issue_width-1:0]      mem_pair_t;
    typedef exec_pkg::reg_fwd_t [exec_pkg::issue_width-1:0]     fwd_pair_t;
    typedef logic [255:0]                                       cmp_t;

    typedef struct packed {
        ex_pair_t        ex;
        logic            pause;
        logic            flush;
        // pipe results before squash, then what the register should load
        mem_pair_t       exp_res;
        mem_pair_t       exp_next;
        logic            exp_flush;
        exec_pkg::addr_t exp_target;
    } row_t;

    localparam int num_random = 40;

    logic            clk;
    logic            arst_n;
    logic            flush;
    logic            pause;
    ex_pair_t        ex;
    mem_pair_t       mem;
    fwd_pair_t       fwd;
    logic            br_flush;
    exec_pkg::addr_t br_target;

    row_t            rows[$];
    exec_pkg::cnt_t  edge_cnt;
    int              cycles = 0;
    int              cycle_limit = 0;

    tb_clock u_clock (
        .clk      (clk),
        .arst_n_o (arst_n)
    );

    execute_stage DUT (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .flush_i         (flush),
        .pause_i         (pause),
        .ex_i            (ex),
        .mem_o           (mem),
        .fwd_o           (fwd),
        .branch_flush_o  (br_flush),
        .branch_target_o (br_target)
    );

    task automatic check_value(input cmp_t actual, input cmp_t expected, input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic needs_main_pipe(input exec_pkg::alu_op_e op);
        return op inside {exec_pkg::op_load, exec_pkg::op_store,
                          exec_pkg::op_rdcnt_lo, exec_pkg::op_rdcnt_hi};
    endfunction

    function automatic exec_pkg::dispatch_ex_t make_instr(
        input exec_pkg::addr_t pc, input exec_pkg::alu_op_e op, input exec_pkg::word_t a,
        input exec_pkg::word_t b, input exec_pkg::word_t imm, input exec_pkg::reg_addr_t rd);
        exec_pkg::dispatch_ex_t e;
        e.valid   = 1'b1;
        e.pc      = pc;
        e.op      = op;
        e.src_a   = a;
        e.src_b   = b;
        e.imm     = imm;
        e.rd_addr = rd;
        e.rd_we   = !(op inside {exec_pkg::op_store, exec_pkg::op_beq, exec_pkg::op_bne,
                                 exec_pkg::op_blt, exec_pkg::op_bge});
        return e;
    endfunction

    function automatic exec_pkg::dispatch_ex_t random_instr(input exec_pkg::addr_t pc,
                                                            input logic allow_mem);
        exec_pkg::dispatch_ex_t e;
        int                     idx;
        // enum order puts the memory and counter ops last
        idx       = int'($urandom % (allow_mem ? 22 : 18));
        e.valid   = ($urandom % 8) != 0;
        e.pc      = pc;
        e.op      = exec_pkg::alu_op_e'(idx);
        e.src_a   = $urandom;
        e.src_b   = ($urandom % 4 == 0) ? e.src_a : $urandom;
        e.imm     = $urandom & 32'h0000_0ffe;
        e.rd_addr = exec_pkg::reg_addr_t'($urandom);
        e.rd_we   = ($urandom % 4) != 0;
        return e;
    endfunction

    task automatic push_row(input exec_pkg::dispatch_ex_t s0, input exec_pkg::dispatch_ex_t s1,
                            input logic pause_v, input logic flush_v);
        row_t r;
        r       = '0;
        r.ex[0] = s0;
        r.ex[1] = s1;
        r.pause = pause_v;
        r.flush = flush_v;
        rows.push_back(r);
    endtask

    // reference for one instruction on either pipe
    function automatic void model_slot(input exec_pkg::dispatch_ex_t e, input exec_pkg::cnt_t cnt,
                                       output exec_pkg::ex_mem_t r, output logic tk,
                                       output exec_pkg::addr_t tgt);
        r   = '0;
        tk  = 1'b0;
        tgt = e.pc + e.imm;
        if (e.valid) begin
            r.valid   = 1'b1;
            r.pc      = e.pc;
            r.rd_addr = e.rd_addr;
            r.rd_we   = e.rd_we;
            case (e.op)
                exec_pkg::op_add:      r.rd_data = e.src_a + e.src_b;
                exec_pkg::op_sub:      r.rd_data = e.src_a - e.src_b;
                exec_pkg::op_and:      r.rd_data = e.src_a & e.src_b;
                exec_pkg::op_or:       r.rd_data = e.src_a | e.src_b;
                exec_pkg::op_xor:      r.rd_data = e.src_a ^ e.src_b;
                exec_pkg::op_sll:      r.rd_data = e.src_a << e.src_b[4:0];
                exec_pkg::op_srl:      r.rd_data = e.src_a >> e.src_b[4:0];
                exec_pkg::op_sra:      r.rd_data = $signed(e.src_a) >>> e.src_b[4:0];
                exec_pkg::op_slt:      r.rd_data = {31'd0, $signed(e.src_a) < $signed(e.src_b)};
                exec_pkg::op_sltu:     r.rd_data = {31'd0, e.src_a < e.src_b};
                exec_pkg::op_lui:      r.rd_data = e.imm;
                exec_pkg::op_beq:      tk = e.src_a == e.src_b;
                exec_pkg::op_bne:      tk = e.src_a != e.src_b;
                exec_pkg::op_blt:      tk = $signed(e.src_a) < $signed(e.src_b);
                exec_pkg::op_bge:      tk = $signed(e.src_a) >= $signed(e.src_b);
                exec_pkg::op_rdcnt_lo: r.rd_data = cnt[31:0];
                exec_pkg::op_rdcnt_hi: r.rd_data = cnt[63:32];
                exec_pkg::op_jal, exec_pkg::op_jalr: begin
                    tk        = 1'b1;
                    r.rd_data = e.pc + 32'd4;
                end
                exec_pkg::op_load, exec_pkg::op_store: begin
                    r.mem_req   = 1'b1;
                    r.mem_we    = e.op == exec_pkg::op_store;
                    r.mem_addr  = e.src_a + e.imm;
                    r.mem_wdata = e.src_b;
                end
                default: ;
            endcase
            if (e.op == exec_pkg::op_jalr) begin
                tgt = (e.src_a + e.imm) & 32'hffff_fffe;
            end
        end
        if (!tk) begin
            tgt = '0;
        end
    endfunction

    // steering, age by pc, squash of the younger record
    function automatic row_t model_row(input row_t rw, input exec_pkg::cnt_t cnt);
        logic              swap;
        logic              main_old;
        logic              tk0;
        logic              tk1;
        exec_pkg::addr_t   t0;
        exec_pkg::addr_t   t1;
        exec_pkg::ex_mem_t r0;
        exec_pkg::ex_mem_t r1;
        swap = rw.ex[1].valid && needs_main_pipe(rw.ex[1].op);
        model_slot(swap ? rw.ex[1] : rw.ex[0], cnt, r0, tk0, t0);
        model_slot(swap ? rw.ex[0] : rw.ex[1], cnt, r1, tk1, t1);
        main_old      = r0.pc < r1.pc;
        rw.exp_res[0] = r0;
        rw.exp_res[1] = r1;
        rw.exp_next   = rw.exp_res;
        rw.exp_flush  = tk0 | tk1;
        rw.exp_target = '0;
        if (main_old ? tk0 : tk1) begin
            rw.exp_target = main_old ? t0 : t1;
            if (main_old) begin
                rw.exp_next[1] = '0;
            end else begin
                rw.exp_next[0] = '0;
            end
        end else if (main_old ? tk1 : tk0) begin
            rw.exp_target = main_old ? t1 : t0;
        end
        return rw;
    endfunction

    function automatic exec_pkg::reg_fwd_t fwd_of(input exec_pkg::ex_mem_t r);
        exec_pkg::reg_fwd_t f;
        f.we   = r.rd_we;
        f.addr = r.rd_addr;
        f.data = r.rd_data;
        return f;
    endfunction

    task automatic load_directed();
        push_row(make_instr(32'h0100, exec_pkg::op_add, 32'd5, 32'd7, 32'd0, 5'd1),
                 make_instr(32'h0104, exec_pkg::op_sub, 32'd5, 32'd9, 32'd0, 5'd2), 1'b0, 1'b0);
        push_row(make_instr(32'h0110, exec_pkg::op_and, 32'hf0f0, 32'hff00, 32'd0, 5'd3),
                 make_instr(32'h0114, exec_pkg::op_or, 32'hf0f0, 32'h0f0f, 32'd0, 5'd4),
                 1'b0, 1'b0);
        push_row(make_instr(32'h0120, exec_pkg::op_xor, 32'haaaa_5555, 32'hffff_0000, 32'd0, 5'd5),
                 make_instr(32'h0124, exec_pkg::op_sll, 32'd1, 32'd31, 32'd0, 5'd6), 1'b0, 1'b0);
        push_row(make_instr(32'h0130, exec_pkg::op_srl, 32'h8000_0000, 32'd4, 32'd0, 5'd7),
                 make_instr(32'h0134, exec_pkg::op_sra, 32'h8000_0000, 32'd36, 32'd0, 5'd8),
                 1'b0, 1'b0);
        push_row(make_instr(32'h0140, exec_pkg::op_slt, 32'hffff_ffff, 32'd1, 32'd0, 5'd9),
                 make_instr(32'h0144, exec_pkg::op_sltu, 32'hffff_ffff, 32'd1, 32'd0, 5'd10),
                 1'b0, 1'b0);
        push_row(make_instr(32'h0150, exec_pkg::op_lui, 32'd0, 32'd0, 32'h1234_5000, 5'd11),
                 make_instr(32'h0154, exec_pkg::op_add, 32'h7fff_ffff, 32'd1, 32'd0, 5'd12),
                 1'b0, 1'b0);
        // memory and counter ops in slot 1 move to the main pipe
        push_row(make_instr(32'h0160, exec_pkg::op_add, 32'd3, 32'd4, 32'd0, 5'd13),
                 make_instr(32'h0164, exec_pkg::op_load, 32'h1000, 32'd0, 32'h24, 5'd14),
                 1'b0, 1'b0);
        push_row(make_instr(32'h0170, exec_pkg::op_xor, 32'd1, 32'd3, 32'd0, 5'd15),
                 make_instr(32'h0174, exec_pkg::op_store, 32'h2000, 32'hdead_beef, 32'd8, 5'd0),
                 1'b0, 1'b0);
        push_row(make_instr(32'h0180, exec_pkg::op_rdcnt_lo, 32'd0, 32'd0, 32'd0, 5'd16),
                 make_instr(32'h0184, exec_pkg::op_add, 32'd2, 32'd2, 32'd0, 5'd17), 1'b0, 1'b0);
        push_row(make_instr(32'h0190, exec_pkg::op_sub, 32'd9, 32'd4, 32'd0, 5'd18),
                 make_instr(32'h0194, exec_pkg::op_rdcnt_hi, 32'd0, 32'd0, 32'd0, 5'd19),
                 1'b0, 1'b0);
        // branches: older taken, younger taken, neither
        push_row(make_instr(32'h01a0, exec_pkg::op_beq, 32'd3, 32'd3, 32'h40, 5'd0),
                 make_instr(32'h01a4, exec_pkg::op_add, 32'd1, 32'd1, 32'd0, 5'd20), 1'b0, 1'b0);
        push_row(make_instr(32'h01b0, exec_pkg::op_add, 32'd6, 32'd1, 32'd0, 5'd21),
                 make_instr(32'h01b4, exec_pkg::op_bne, 32'd1, 32'd2, 32'hffff_fff8, 5'd0),
                 1'b0, 1'b0);
        push_row(make_instr(32'h01c0, exec_pkg::op_blt, 32'd5, 32'd3, 32'h20, 5'd0),
                 make_instr(32'h01c4, exec_pkg::op_bge, 32'hffff_fffe, 32'd1, 32'h20, 5'd0),
                 1'b0, 1'b0);
        push_row(make_instr(32'h01d0, exec_pkg::op_jal, 32'd0, 32'd0, 32'h100, 5'd1),
                 make_instr(32'h01d4, exec_pkg::op_or, 32'd8, 32'd1, 32'd0, 5'd22), 1'b1, 1'b0);
        push_row(make_instr(32'h01e0, exec_pkg::op_jalr, 32'h3001, 32'd0, 32'h10, 5'd1),
                 make_instr(32'h01e4, exec_pkg::op_and, 32'hff, 32'h0f, 32'd0, 5'd23), 1'b0, 1'b0);
        push_row(make_instr(32'h01f0, exec_pkg::op_store, 32'h2100, 32'h55, 32'd4, 5'd0),
                 make_instr(32'h01f4, exec_pkg::op_bge, 32'd4, 32'd4, 32'h30, 5'd0), 1'b0, 1'b1);
        // older branch on the deputy pipe squashes the load on the main pipe
        push_row(make_instr(32'h0200, exec_pkg::op_blt, 32'hffff_fffb, 32'd2, 32'h60, 5'd0),
                 make_instr(32'h0204, exec_pkg::op_load, 32'h1800, 32'd0, 32'd0, 5'd24),
                 1'b0, 1'b0);
        push_row('0, '0, 1'b0, 1'b0);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Finished with errors");
            $fatal(1, "timeout, the test did not reach its end within %0d cycles", cycles);
        end
    end

    initial begin
        row_t                   cur;
        mem_pair_t              model_q;
        exec_pkg::dispatch_ex_t s0;

        ex       = '0;
        pause    = 1'b0;
        flush    = 1'b0;
        edge_cnt = '0;
        model_q  = '0;
        void'($urandom(32'hea52_0f5a));

        load_directed();
        for (int k = 0; k < num_random; k++) begin
            s0 = random_instr(32'h0000_2000 + 32'(k) * 32'h40, 1'b1);
            push_row(s0, random_instr(s0.pc + 32'd4, !needs_main_pipe(s0.op)),
                     ($urandom % 8) == 0, ($urandom % 16) == 0);
        end
        cycle_limit = 2 * rows.size() + 20;

        repeat (2) @(posedge clk);
        #1;
        check_value(cmp_t'(mem[0]), '0, "mem_o[0] during reset");
        check_value(cmp_t'(mem[1]), '0, "mem_o[1] during reset");
        check_value(cmp_t'(br_flush), '0, "branch_flush_o during reset");
        wait (arst_n === 1'b1);

        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            edge_cnt = edge_cnt + 1;
            if (i > 0) begin
                if (rows[i-1].flush) begin
                    model_q = '0;
                end else if (!rows[i-1].pause) begin
                    model_q = rows[i-1].exp_next;
                end
            end
            #1;
            check_value(cmp_t'(mem[0]), cmp_t'(model_q[0]),
                        $sformatf("mem_o[0] after row %0d", i));
            check_value(cmp_t'(mem[1]), cmp_t'(model_q[1]),
                        $sformatf("mem_o[1] after row %0d", i));
            if (i < rows.size()) begin
                cur     = model_row(rows[i], edge_cnt);
                rows[i] = cur;
                #1;
                ex    = cur.ex;
                pause = cur.pause;
                flush = cur.flush;
                #5;
                check_value(cmp_t'(br_flush), cmp_t'(cur.exp_flush),
                            $sformatf("branch_flush_o row %0d", i));
                check_value(cmp_t'(br_target), cmp_t'(cur.exp_target),
                            $sformatf("branch_target_o row %0d", i));
                check_value(cmp_t'(fwd[0]), cmp_t'(fwd_of(cur.exp_res[0])),
                            $sformatf("fwd_o[0] row %0d", i));
                check_value(cmp_t'(fwd[1]), cmp_t'(fwd_of(cur.exp_res[1])),
                            $sformatf("fwd_o[1] row %0d", i));
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== build.f ====
source/exec_pkg.sv
source/exec_alu.sv
source/branch_resolve.sv
source/main_pipe.sv
source/deputy_pipe.sv
source/execute_stage.sv
verif/tb_clock.sv
verif/tb_execute_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 --top-module tb_execute_stage -f build.f &&
    ./obj_dir/Vtb_execute_stage ||
    { echo "execute stage simulation failed" >&2; exit 1; }
